/* hw/bp_params.svh */
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// fetch address width
`define BP_PC_W 32

// bimodal table, 256 entries
`define BP_BASE_IDX_W 8

// tagged tables, 64 entries each
`define BP_TAG_IDX_W 6

// partial tag stored per tagged entry
`define BP_TAG_W 5

// history lengths of the two tagged tables
`define BP_HIST_LEN_1 8
// longest table also sets the outcome register width
`define BP_HIST_LEN_2 16

// weakly taken
`define BP_CNT2_INIT 2'd2
// weakly taken, tagged side
`define BP_CNT3_INIT 3'd4

`endif

/* hw/isa_pkg.sv */
`include "bp_params.svh"

package isa_pkg;

	// execute-side operation code
	typedef logic [5:0] alu_op_t;

	// conditional branches and the unconditional jump
	localparam alu_op_t BEQ = 6'b001011;
	localparam alu_op_t BLT = 6'b001100;
	localparam alu_op_t BGE = 6'b001101;
	localparam alu_op_t JAL = 6'b001110;

	typedef logic [`BP_PC_W-1:0] inst_addr_t;

endpackage

/* hw/tage_pkg.sv */
`include "bp_params.svh"

package tage_pkg;

	// bimodal saturating counter
	typedef logic [1:0] cnt2_t;

	// tagged saturating counter
	typedef logic [2:0] cnt3_t;

	// table indices
	typedef logic [`BP_BASE_IDX_W-1:0] base_idx_t;
	typedef logic [`BP_TAG_IDX_W-1:0] tag_idx_t;

	// partial tag, also the width of the tag folds
	typedef logic [`BP_TAG_W-1:0] tag_t;

	// which table supplied the prediction
	typedef enum logic [1:0] {
		PROV_BASE = 2'd0,
		PROV_T1   = 2'd1,
		PROV_T2   = 2'd2
	} provider_t;

endpackage

/* hw/global_history.sv */
`timescale 1ns/1ps
`include "bp_params.svh"

module global_history import tage_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     i_we,
	input  logic     i_jmp,
	output tag_idx_t o_fold_idx_1,
	output tag_idx_t o_fold_idx_2,
	output tag_t     o_fold_tag_1,
	output tag_t     o_fold_tag_2
);

	// newest outcome in bit 0
	logic [`BP_HIST_LEN_2-1:0] hist;

	// rotate within width bits, fold in the new outcome
	// and cancel the bit that drops out of the window
	// narrower tag folds ride zero-extended in the index type
	function automatic tag_idx_t fold_next(input tag_idx_t fold, input int width,
		input int pos, input logic in_bit, input logic out_bit);
		tag_idx_t mask;
		tag_idx_t rot;
		mask = tag_idx_t'((1 << width) - 1);
		rot = ((fold << 1) | (fold >> (width - 1))) & mask;
		rot[0] = rot[0] ^ in_bit;
		rot[pos] = rot[pos] ^ out_bit;
		return rot;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hist <= '0;
			o_fold_idx_1 <= '0;
			o_fold_idx_2 <= '0;
			o_fold_tag_1 <= '0;
			o_fold_tag_2 <= '0;
		end else if (i_we) begin
			hist <= {hist[`BP_HIST_LEN_2-2:0], i_jmp};
			// leaving bits are read before the shift lands
			o_fold_idx_1 <= fold_next(o_fold_idx_1, $bits(tag_idx_t),
				`BP_HIST_LEN_1 % $bits(tag_idx_t), i_jmp, hist[`BP_HIST_LEN_1-1]);
			o_fold_idx_2 <= fold_next(o_fold_idx_2, $bits(tag_idx_t),
				`BP_HIST_LEN_2 % $bits(tag_idx_t), i_jmp, hist[`BP_HIST_LEN_2-1]);
			o_fold_tag_1 <= tag_t'(fold_next(tag_idx_t'(o_fold_tag_1), $bits(tag_t),
				`BP_HIST_LEN_1 % $bits(tag_t), i_jmp, hist[`BP_HIST_LEN_1-1]));
			o_fold_tag_2 <= tag_t'(fold_next(tag_idx_t'(o_fold_tag_2), $bits(tag_t),
				`BP_HIST_LEN_2 % $bits(tag_t), i_jmp, hist[`BP_HIST_LEN_2-1]));
		end
	end

endmodule

/* hw/base_table.sv */
`timescale 1ns/1ps
`include "bp_params.svh"

module base_table import isa_pkg::*; import tage_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  inst_addr_t i_inst_addr,
	input  logic       i_capture,
	input  logic       i_we,
	input  logic       i_jmp,
	output logic       o_taken
);

	localparam int ENTRIES = 1 << `BP_BASE_IDX_W;

	cnt2_t     cnt_q [ENTRIES];
	base_idx_t idx;
	base_idx_t rec_idx;
	cnt2_t     cnt_next;

	// plain pc index, no history
	assign idx = i_inst_addr[`BP_BASE_IDX_W-1:0];
	// 2 and 3 mean taken
	assign o_taken = (cnt_q[idx] > 2'd1);

	// index of the branch still waiting for its outcome
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rec_idx <= '0;
		else if (i_capture)
			rec_idx <= idx;
	end

	// saturating step of the recorded entry
	always_comb begin
		cnt_next = cnt_q[rec_idx];
		if (i_jmp && cnt_next != 2'd3)
			cnt_next = cnt_next + 2'd1;
		else if (!i_jmp && cnt_next != 2'd0)
			cnt_next = cnt_next - 2'd1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ENTRIES; i++)
				cnt_q[i] <= `BP_CNT2_INIT;
		end else if (i_we) begin
			cnt_q[rec_idx] <= cnt_next;
		end
	end

endmodule

/* hw/tagged_table.sv */
`timescale 1ns/1ps
`include "bp_params.svh"

module tagged_table import isa_pkg::*; import tage_pkg::*; #(
	parameter int HIST_LEN = `BP_HIST_LEN_1
) (
	input  logic       clk,
	input  logic       rst_n,
	input  inst_addr_t i_inst_addr,
	input  tag_idx_t   i_fold_idx,
	input  tag_t       i_fold_tag,
	input  logic       i_capture,
	input  logic       i_upd,
	input  logic       i_alloc,
	input  logic       i_jmp,
	output logic       o_hit,
	output logic       o_taken
);

	localparam int ENTRIES = 1 << `BP_TAG_IDX_W;

	tag_t     tag_q [ENTRIES];
	cnt3_t    cnt_q [ENTRIES];
	tag_idx_t idx;
	tag_t     tag;
	tag_idx_t rec_idx;
	tag_t     rec_tag;
	cnt3_t    cnt_next;

	// folds come from the shared history, so the length must fit it
	if (HIST_LEN < 1 || HIST_LEN > `BP_HIST_LEN_2) begin : g_len_check
		$error("tagged_table: HIST_LEN %0d outside history register", HIST_LEN);
	end

	// pc hashed with this table's folded history
	assign idx = i_inst_addr[`BP_TAG_IDX_W-1:0] ^ i_fold_idx;
	assign tag = i_inst_addr[`BP_TAG_W-1:0] ^ i_fold_tag;

	assign o_hit = (tag_q[idx] == tag);
	// upper half of the range means taken
	assign o_taken = (cnt_q[idx] > 3'd3);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rec_idx <= '0;
			rec_tag <= '0;
		end else if (i_capture) begin
			rec_idx <= idx;
			rec_tag <= tag;
		end
	end

	always_comb begin
		cnt_next = cnt_q[rec_idx];
		if (i_jmp && cnt_next != 3'd7)
			cnt_next = cnt_next + 3'd1;
		else if (!i_jmp && cnt_next != 3'd0)
			cnt_next = cnt_next - 3'd1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ENTRIES; i++) begin
				tag_q[i] <= '0;
				cnt_q[i] <= `BP_CNT3_INIT;
			end
		end else if (i_alloc) begin
			// new entry starts weak, leaning to the resolved outcome
			tag_q[rec_idx] <= rec_tag;
			cnt_q[rec_idx] <= i_jmp ? 3'd4 : 3'd3;
		end else if (i_upd) begin
			cnt_q[rec_idx] <= cnt_next;
		end
	end

	// provider update and allocation target different tables
	a_upd_alloc_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_upd && i_alloc));

endmodule

/* hw/provider_select.sv */
`timescale 1ns/1ps

module provider_select import isa_pkg::*; import tage_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  alu_op_t    i_alu_op,
	input  inst_addr_t i_inst_addr,
	input  inst_addr_t i_imm,
	input  logic       i_base_taken,
	input  logic       i_t1_hit,
	input  logic       i_t1_taken,
	input  logic       i_t2_hit,
	input  logic       i_t2_taken,
	input  logic       i_we,
	input  logic       i_jmp,
	output logic       o_is_branch,
	output logic       o_jmp_predict,
	output inst_addr_t o_new_inst_addr,
	output logic       o_upd_t1,
	output logic       o_upd_t2,
	output logic       o_alloc_t1,
	output logic       o_alloc_t2
);

	provider_t prov;
	logic      pred_raw;
	provider_t rec_prov;
	logic      rec_pred;
	logic      mispredict;

	// conditional branches only, JAL is not predicted here
	assign o_is_branch = (i_alu_op == BEQ) || (i_alu_op == BLT) || (i_alu_op == BGE);

	// longest history hit wins
	assign prov = i_t2_hit ? PROV_T2 : (i_t1_hit ? PROV_T1 : PROV_BASE);

	always_comb begin
		case (prov)
			PROV_T2: pred_raw = i_t2_taken;
			PROV_T1: pred_raw = i_t1_taken;
			default: pred_raw = i_base_taken;
		endcase
	end

	assign o_jmp_predict = o_is_branch && pred_raw;
	assign o_new_inst_addr = o_jmp_predict ? (i_inst_addr + i_imm) : i_inst_addr;

	// lookup context kept until the outcome arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rec_prov <= PROV_BASE;
			rec_pred <= 1'b0;
		end else if (o_is_branch) begin
			rec_prov <= prov;
			rec_pred <= pred_raw;
		end
	end

	assign mispredict = (i_jmp != rec_pred);

	// provider trains its own counter
	assign o_upd_t1 = i_we && (rec_prov == PROV_T1);
	assign o_upd_t2 = i_we && (rec_prov == PROV_T2);
	// wrong guess moves one table up in history length
	assign o_alloc_t1 = i_we && mispredict && (rec_prov == PROV_BASE);
	assign o_alloc_t2 = i_we && mispredict && (rec_prov == PROV_T1);

	// outcome never shares a cycle with a lookup, else the records race
	a_no_we_on_branch: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_we && o_is_branch));

endmodule

/* hw/bp_top.sv */
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_top import isa_pkg::*; import tage_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  alu_op_t    i_alu_op,
	input  inst_addr_t i_inst_addr,
	input  inst_addr_t i_imm,
	input  logic       i_we,
	input  logic       i_jmp,
	output logic       o_jmp_predict,
	output inst_addr_t o_new_inst_addr
);

	logic     is_branch;
	logic     base_taken;
	logic     t1_hit;
	logic     t1_taken;
	logic     t2_hit;
	logic     t2_taken;
	logic     upd_t1;
	logic     upd_t2;
	logic     alloc_t1;
	logic     alloc_t2;
	tag_idx_t fold_idx_1;
	tag_idx_t fold_idx_2;
	tag_t     fold_tag_1;
	tag_t     fold_tag_2;

	// outcome history and per-table folds
	global_history global_history_i (
		.clk(clk), .rst_n(rst_n), .i_we(i_we), .i_jmp(i_jmp),
		.o_fold_idx_1(fold_idx_1), .o_fold_idx_2(fold_idx_2),
		.o_fold_tag_1(fold_tag_1), .o_fold_tag_2(fold_tag_2)
	);

	// base table trains on every outcome
	base_table base_table_i (
		.clk(clk), .rst_n(rst_n), .i_inst_addr(i_inst_addr),
		.i_capture(is_branch), .i_we(i_we), .i_jmp(i_jmp), .o_taken(base_taken)
	);

	// short history table
	tagged_table #(.HIST_LEN(`BP_HIST_LEN_1)) tagged_table_1_i (
		.clk(clk), .rst_n(rst_n), .i_inst_addr(i_inst_addr),
		.i_fold_idx(fold_idx_1), .i_fold_tag(fold_tag_1), .i_capture(is_branch),
		.i_upd(upd_t1), .i_alloc(alloc_t1), .i_jmp(i_jmp),
		.o_hit(t1_hit), .o_taken(t1_taken)
	);

	// long history table
	tagged_table #(.HIST_LEN(`BP_HIST_LEN_2)) tagged_table_2_i (
		.clk(clk), .rst_n(rst_n), .i_inst_addr(i_inst_addr),
		.i_fold_idx(fold_idx_2), .i_fold_tag(fold_tag_2), .i_capture(is_branch),
		.i_upd(upd_t2), .i_alloc(alloc_t2), .i_jmp(i_jmp),
		.o_hit(t2_hit), .o_taken(t2_taken)
	);

	provider_select provider_select_i (
		.clk(clk), .rst_n(rst_n), .i_alu_op(i_alu_op), .i_inst_addr(i_inst_addr),
		.i_imm(i_imm), .i_base_taken(base_taken), .i_t1_hit(t1_hit),
		.i_t1_taken(t1_taken), .i_t2_hit(t2_hit), .i_t2_taken(t2_taken),
		.i_we(i_we), .i_jmp(i_jmp), .o_is_branch(is_branch),
		.o_jmp_predict(o_jmp_predict), .o_new_inst_addr(o_new_inst_addr),
		.o_upd_t1(upd_t1), .o_upd_t2(upd_t2),
		.o_alloc_t1(alloc_t1), .o_alloc_t2(alloc_t2)
	);

endmodule

/* sim/bp_checker.sv */
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_checker import isa_pkg::*; import tage_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  alu_op_t    i_alu_op,
	input  inst_addr_t i_inst_addr,
	input  inst_addr_t i_imm,
	input  logic       i_we,
	input  logic       i_jmp,
	input  logic       i_jmp_predict,
	input  inst_addr_t i_new_inst_addr,
	output int         o_checks,
	output int         o_errors,
	output int         o_t1_used,
	output int         o_t2_used
);

	localparam int BASE_N = 1 << `BP_BASE_IDX_W;
	localparam int TAG_N = 1 << `BP_TAG_IDX_W;

	// mirrored tables, index 0 is table 1
	cnt2_t     base_cnt [BASE_N];
	tag_t      tt_tag [2][TAG_N];
	cnt3_t     tt_cnt [2][TAG_N];
	// entries written by allocation since reset
	logic      tt_alloc [2][TAG_N];
	// outcome history, newest in bit 0
	logic [`BP_HIST_LEN_2-1:0] hist;
	tag_idx_t  fold_idx1;
	tag_idx_t  fold_idx2;
	tag_t      fold_tag1;
	tag_t      fold_tag2;
	// context of the branch waiting for its outcome
	base_idx_t rec_bidx;
	tag_idx_t  rec_idx [2];
	tag_t      rec_tag [2];
	provider_t rec_prov;
	logic      rec_pred;
	int        n_checks = 0;
	int        n_errors = 0;
	int        n_t1 = 0;
	int        n_t2 = 0;

	assign o_checks = n_checks;
	assign o_errors = n_errors;
	assign o_t1_used = n_t1;
	assign o_t2_used = n_t2;

	function automatic logic is_cond_branch(input alu_op_t op);
		return (op == BEQ) || (op == BLT) || (op == BGE);
	endfunction

	function automatic tag_idx_t hash_idx(input inst_addr_t pc, input tag_idx_t fold);
		return pc[`BP_TAG_IDX_W-1:0] ^ fold;
	endfunction

	function automatic tag_t hash_tag(input inst_addr_t pc, input tag_t fold);
		return pc[`BP_TAG_W-1:0] ^ fold;
	endfunction

	// rotate left one, new outcome into bit 0, leaving bit into pos
	function automatic tag_idx_t idx_fold_step(input tag_idx_t f, input int pos,
		input logic new_bit, input logic old_bit);
		tag_idx_t r;
		r = {f[`BP_TAG_IDX_W-2:0], f[`BP_TAG_IDX_W-1]};
		r[0] = r[0] ^ new_bit;
		r[pos] = r[pos] ^ old_bit;
		return r;
	endfunction

	function automatic tag_t tag_fold_step(input tag_t f, input int pos,
		input logic new_bit, input logic old_bit);
		tag_t r;
		r = {f[`BP_TAG_W-2:0], f[`BP_TAG_W-1]};
		r[0] = r[0] ^ new_bit;
		r[pos] = r[pos] ^ old_bit;
		return r;
	endfunction

	function automatic cnt2_t step2(input cnt2_t c, input logic up);
		if (up)
			return (c == 2'd3) ? c : c + 2'd1;
		else
			return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	function automatic cnt3_t step3(input cnt3_t c, input logic up);
		if (up)
			return (c == 3'd7) ? c : c + 3'd1;
		else
			return (c == 3'd0) ? c : c - 3'd1;
	endfunction

	// expected direction, next fetch address and provider
	function automatic void predict_ref(input alu_op_t op, input inst_addr_t pc,
		input inst_addr_t imm, output logic taken, output inst_addr_t nxt,
		output provider_t prov);
		tag_idx_t i1;
		tag_idx_t i2;
		logic     dir;
		i1 = hash_idx(pc, fold_idx1);
		i2 = hash_idx(pc, fold_idx2);
		if (tt_tag[1][i2] == hash_tag(pc, fold_tag2)) begin
			prov = PROV_T2;
			dir = (tt_cnt[1][i2] > 3'd3);
		end else if (tt_tag[0][i1] == hash_tag(pc, fold_tag1)) begin
			prov = PROV_T1;
			dir = (tt_cnt[0][i1] > 3'd3);
		end else begin
			prov = PROV_BASE;
			dir = (base_cnt[pc[`BP_BASE_IDX_W-1:0]] > 2'd1);
		end
		taken = is_cond_branch(op) && dir;
		nxt = taken ? pc + imm : pc;
	endfunction

	function automatic void clear_model();
		for (int i = 0; i < BASE_N; i++)
			base_cnt[i] = `BP_CNT2_INIT;
		for (int i = 0; i < TAG_N; i++) begin
			tt_tag[0][i] = '0;
			tt_tag[1][i] = '0;
			tt_cnt[0][i] = `BP_CNT3_INIT;
			tt_cnt[1][i] = `BP_CNT3_INIT;
			tt_alloc[0][i] = 1'b0;
			tt_alloc[1][i] = 1'b0;
		end
		hist = '0;
		fold_idx1 = '0;
		fold_idx2 = '0;
		fold_tag1 = '0;
		fold_tag2 = '0;
		rec_bidx = '0;
		rec_idx[0] = '0;
		rec_idx[1] = '0;
		rec_tag[0] = '0;
		rec_tag[1] = '0;
		rec_prov = PROV_BASE;
		rec_pred = 1'b0;
	endfunction

	// inputs settle after the rising edge, compare mid cycle,
	// then apply what the next rising edge will do
	always @(negedge clk) begin : model
		logic       exp_taken;
		inst_addr_t exp_nxt;
		provider_t  exp_prov;
		logic       miss;
		if (!rst_n) begin
			clear_model();
		end else begin
			predict_ref(i_alu_op, i_inst_addr, i_imm, exp_taken, exp_nxt, exp_prov);
			n_checks++;
			if (i_jmp_predict !== exp_taken) begin
				n_errors++;
				$display("ERROR %0t o_jmp_predict expected %b got %b",
					$time, exp_taken, i_jmp_predict);
			end
			if (i_new_inst_addr !== exp_nxt) begin
				n_errors++;
				$display("ERROR %0t o_new_inst_addr expected %h got %h",
					$time, exp_nxt, i_new_inst_addr);
			end
			// outcome trains the recorded branch
			if (i_we) begin
				miss = (i_jmp != rec_pred);
				base_cnt[rec_bidx] = step2(base_cnt[rec_bidx], i_jmp);
				if (rec_prov == PROV_T1)
					tt_cnt[0][rec_idx[0]] = step3(tt_cnt[0][rec_idx[0]], i_jmp);
				if (rec_prov == PROV_T2)
					tt_cnt[1][rec_idx[1]] = step3(tt_cnt[1][rec_idx[1]], i_jmp);
				// one table up from the provider takes the entry
				if (miss && rec_prov != PROV_T2) begin
					if (rec_prov == PROV_BASE) begin
						tt_tag[0][rec_idx[0]] = rec_tag[0];
						tt_cnt[0][rec_idx[0]] = i_jmp ? 3'd4 : 3'd3;
						tt_alloc[0][rec_idx[0]] = 1'b1;
					end else begin
						tt_tag[1][rec_idx[1]] = rec_tag[1];
						tt_cnt[1][rec_idx[1]] = i_jmp ? 3'd4 : 3'd3;
						tt_alloc[1][rec_idx[1]] = 1'b1;
					end
				end
				fold_idx1 = idx_fold_step(fold_idx1, `BP_HIST_LEN_1 % `BP_TAG_IDX_W,
					i_jmp, hist[`BP_HIST_LEN_1-1]);
				fold_idx2 = idx_fold_step(fold_idx2, `BP_HIST_LEN_2 % `BP_TAG_IDX_W,
					i_jmp, hist[`BP_HIST_LEN_2-1]);
				fold_tag1 = tag_fold_step(fold_tag1, `BP_HIST_LEN_1 % `BP_TAG_W,
					i_jmp, hist[`BP_HIST_LEN_1-1]);
				fold_tag2 = tag_fold_step(fold_tag2, `BP_HIST_LEN_2 % `BP_TAG_W,
					i_jmp, hist[`BP_HIST_LEN_2-1]);
				hist = {hist[`BP_HIST_LEN_2-2:0], i_jmp};
			end
			// lookup context, never in an update cycle
			if (is_cond_branch(i_alu_op)) begin
				rec_bidx = i_inst_addr[`BP_BASE_IDX_W-1:0];
				rec_idx[0] = hash_idx(i_inst_addr, fold_idx1);
				rec_idx[1] = hash_idx(i_inst_addr, fold_idx2);
				rec_tag[0] = hash_tag(i_inst_addr, fold_tag1);
				rec_tag[1] = hash_tag(i_inst_addr, fold_tag2);
				rec_prov = exp_prov;
				rec_pred = exp_taken;
				// reset-valued zero tags also hit, only allocated entries count
				if (exp_prov == PROV_T1 && tt_alloc[0][rec_idx[0]])
					n_t1++;
				if (exp_prov == PROV_T2 && tt_alloc[1][rec_idx[1]])
					n_t2++;
			end
		end
	end

endmodule

/* sim/bp_tb.sv */
`timescale 1ns/1ps
`include "bp_params.svh"

module bp_tb import isa_pkg::*; ();

	localparam int N_BRANCH = 1500;
	localparam int POOL_N = 16;
	localparam int MAX_GAP = 2;
	localparam int RESET_CYCLES = 8;
	// a branch spans at most lookup, update and two gaps, plus slack for resets
	localparam int TIMEOUT_CYCLES = N_BRANCH * (2 + 2 * MAX_GAP) + 3000;

	logic       clk;
	logic       rst_n;
	alu_op_t    alu_op;
	inst_addr_t inst_addr;
	inst_addr_t imm;
	logic       we;
	logic       jmp;
	logic       jmp_predict;
	inst_addr_t new_inst_addr;

	// small pc pool so entries alias and tags hit
	inst_addr_t pc_pool [POOL_N];
	// next outcome of the alternating pcs
	logic       alt_state [POOL_N];
	int         cycle_cnt = 0;
	int         checks;
	int         errors;
	int         t1_used;
	int         t2_used;

	bp_top bp_top_i (
		.clk(clk), .rst_n(rst_n), .i_alu_op(alu_op), .i_inst_addr(inst_addr),
		.i_imm(imm), .i_we(we), .i_jmp(jmp),
		.o_jmp_predict(jmp_predict), .o_new_inst_addr(new_inst_addr)
	);

	bp_checker bp_checker_i (
		.clk(clk), .rst_n(rst_n), .i_alu_op(alu_op), .i_inst_addr(inst_addr),
		.i_imm(imm), .i_we(we), .i_jmp(jmp), .i_jmp_predict(jmp_predict),
		.i_new_inst_addr(new_inst_addr), .o_checks(checks), .o_errors(errors),
		.o_t1_used(t1_used), .o_t2_used(t2_used)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// any op except the three conditional branches, JAL often
	function automatic alu_op_t other_op(input logic [31:0] r);
		alu_op_t op;
		op = r[5:0];
		if (r[8:6] == 3'd0 || op == BEQ || op == BLT || op == BGE)
			op = JAL;
		return op;
	endfunction

	task automatic idle_cycles(input int n);
		logic [31:0] r;
		repeat (n) begin
			r = $urandom;
			@(posedge clk);
			alu_op <= other_op(r);
			inst_addr <= $urandom;
			imm <= $urandom;
			we <= 1'b0;
			jmp <= r[9];
		end
	endtask

	task automatic issue_branch(input int slot);
		logic [31:0] r;
		r = $urandom;
		@(posedge clk);
		case (r[1:0])
			2'd0: alu_op <= BEQ;
			2'd1: alu_op <= BLT;
			default: alu_op <= BGE;
		endcase
		inst_addr <= pc_pool[slot];
		// short signed offset
		imm <= {{20{r[13]}}, r[13:2]};
		we <= 1'b0;
	endtask

	// pattern kind by slot: taken, not taken, alternating
	task automatic resolve_branch(input int slot);
		logic [31:0] r;
		logic taken;
		r = $urandom;
		case (slot % 3)
			0: taken = 1'b1;
			1: taken = 1'b0;
			default: begin
				taken = alt_state[slot];
				alt_state[slot] = ~alt_state[slot];
			end
		endcase
		@(posedge clk);
		alu_op <= other_op(r);
		inst_addr <= $urandom;
		imm <= $urandom;
		we <= 1'b1;
		jmp <= taken;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		alu_op <= JAL;
		we <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic run_branches(input int n);
		int slot;
		repeat (n) begin
			slot = $urandom_range(POOL_N - 1, 0);
			issue_branch(slot);
			idle_cycles($urandom_range(MAX_GAP, 0));
			resolve_branch(slot);
			idle_cycles($urandom_range(MAX_GAP, 0));
		end
	endtask

	initial begin
		logic [31:0] r;
		int i;
		r = $urandom(32'hf11d_5321);
		rst_n = 1'b0;
		alu_op = JAL;
		inst_addr = '0;
		imm = '0;
		we = 1'b0;
		jmp = 1'b0;
		for (i = 0; i < POOL_N; i++) begin
			r = $urandom;
			// word aligned, bits 9:8 lie above the base index
			pc_pool[i] = {22'd0, r[9:2], 2'b00};
			alt_state[i] = r[10];
		end
		apply_reset();
		run_branches(N_BRANCH / 2);
		// second reset while tables are trained
		apply_reset();
		run_branches(N_BRANCH - N_BRANCH / 2);
		idle_cycles(2);
		if (checks == 0)
			$display("no prediction was checked");
		if (t1_used == 0)
			$display("no allocated table 1 entry ever provided a prediction");
		if (t2_used == 0)
			$display("no allocated table 2 entry ever provided a prediction");
		$display("bp_tb: %0d checks, %0d errors, %0d table 1 and %0d table 2 predictions",
			checks, errors, t1_used, t2_used);
		if (errors == 0 && checks > 0 && t1_used > 0 && t2_used > 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* bp_top.f */
+incdir+hw
hw/isa_pkg.sv
hw/tage_pkg.sv
hw/global_history.sv
hw/base_table.sv
hw/tagged_table.sv
hw/provider_select.sv
hw/bp_top.sv
sim/bp_checker.sv
sim/bp_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the predictor testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f bp_top.f --top-module bp_tb -o bp_sim; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/bp_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qxF ">>> PASS" <<< "$out"; then
	exit 0
fi
exit 1
